// File: verilog/ahb_axi_pkg.sv
// AHB-Lite to AXI4 bridge shared definitions
// Bus widths, transfer and size codes, local memory regions
// and the bridge FSM state encoding
package ahb_axi_pkg;

   // ********************************************************************
   // Bus field types
   // ********************************************************************
   typedef logic [31:0] addr_t;   // Byte address on both buses
   typedef logic [63:0] data_t;   // Read and write data
   typedef logic [7:0]  strb_t;   // One bit per byte lane
   typedef logic [2:0]  hsize_t;  // log2 of transfer bytes
   typedef logic [1:0]  htrans_t; // AHB transfer type
   typedef logic [1:0]  resp_t;   // AXI OKAY/EXOKAY/SLVERR/DECERR

   // Bridge FSM
   typedef enum logic [1:0] {
      IDLE = 2'b00,  // No transfer in data phase
      WR   = 2'b01,  // Write data phase
      RD   = 2'b10,  // Read address captured, AR not yet buffered
      PEND = 2'b11   // AR sent, waiting on R beat
   } bridge_state_t;

   // AHB transfer types
   localparam htrans_t HTRANS_IDLE   = 2'b00;
   localparam htrans_t HTRANS_BUSY   = 2'b01;
   localparam htrans_t HTRANS_NONSEQ = 2'b10;

   // Size codes, shared by AHB hsize and AXI axsize
   localparam hsize_t SIZE_BYTE  = 3'd0;
   localparam hsize_t SIZE_HALF  = 3'd1;
   localparam hsize_t SIZE_WORD  = 3'd2;
   localparam hsize_t SIZE_DWORD = 3'd3;

   // ********************************************************************
   // Local memory regions
   // ********************************************************************
   // Sizes are powers of two and bases are aligned to their size
   localparam addr_t DCCM_BASE = 32'hF004_0000;  // Data memory
   localparam addr_t DCCM_SIZE = 32'h0001_0000;  // 64 KiB
   localparam addr_t ICCM_BASE = 32'hEE00_0000;  // Instruction memory
   localparam addr_t ICCM_SIZE = 32'h0001_0000;  // 64 KiB

endpackage

// File: verilog/ahb_access_check.sv
// Access legality check for the bridge
// Decodes the DCCM and ICCM regions and flags transfers that
// fall outside them, target the ICCM, write the DCCM below
// word size, or are misaligned for their size
`timescale 1ns/1ps

module ahb_access_check
   import ahb_axi_pkg::*;
(
   input  addr_t  addr_q,
   input  hsize_t size_q,
   input  logic   write_q,
   output logic   access_err
);

   logic in_dccm;
   logic in_iccm;
   logic narrow;                         // Byte or halfword
   logic misaligned;
   logic bad_size;                       // Codes above doubleword

   // Regions are size aligned, so compare only the upper bits
   assign in_dccm = (addr_q & ~(DCCM_SIZE - 32'd1)) == DCCM_BASE;
   assign in_iccm = (addr_q & ~(ICCM_SIZE - 32'd1)) == ICCM_BASE;

   assign narrow   = (size_q == SIZE_BYTE) | (size_q == SIZE_HALF);
   assign bad_size = size_q[2];

   always_comb begin
      case (size_q)
         SIZE_HALF:  misaligned = addr_q[0];
         SIZE_WORD:  misaligned = |addr_q[1:0];
         SIZE_DWORD: misaligned = |addr_q[2:0];
         default:    misaligned = 1'b0;  // Bytes always aligned
      endcase
   end

   assign access_err = ~(in_dccm | in_iccm) |   // Unmapped
                       in_iccm |                // No bus access to ICCM
                       (in_dccm & write_q & narrow) |
                       misaligned |
                       bad_size;

endmodule

// File: verilog/axi_cmd_buf.sv
// One-entry AXI command buffer for the bridge
// Holds one read or write command, builds the write strobe
// from size and address, and presents the entry on AW+W or AR
// until the slave completes the handshake
`timescale 1ns/1ps

module axi_cmd_buf
   import ahb_axi_pkg::*;
(
   input  logic   bus_clk,
   input  logic   arst_n,
   input  logic   cmd_load,
   input  logic   cmd_flush,
   input  addr_t  addr_q,
   input  hsize_t size_q,
   input  logic   write_q,
   input  data_t  hwdata,
   output logic   cmd_full,

   // Write address and data
   output logic   awvalid,
   output addr_t  awaddr,
   output hsize_t awsize,
   input  logic   awready,
   output logic   wvalid,
   output data_t  wdata,
   output strb_t  wstrb,
   input  logic   wready,

   // Read address
   output logic   arvalid,
   output addr_t  araddr,
   output hsize_t arsize,
   input  logic   arready
);

   logic   vld_q;                        // Entry holds a command
   logic   wr_q;                         // Entry is a write
   addr_t  cmd_addr;
   hsize_t cmd_size;
   data_t  cmd_wdata;
   strb_t  cmd_strb;
   strb_t  strb_nxt;
   logic   done;                         // Handshake completes this cycle

   // ********************************************************************
   // Strobe from size and low address bits
   // ********************************************************************
   always_comb begin
      case (size_q)
         SIZE_BYTE: strb_nxt = 8'b0000_0001 << addr_q[2:0];
         SIZE_HALF: strb_nxt = 8'b0000_0011 << addr_q[2:0];
         SIZE_WORD: strb_nxt = 8'b0000_1111 << addr_q[2:0];
         default:   strb_nxt = 8'b1111_1111;  // All lanes
      endcase
   end

   // AW and W leave together, so both readies must be high
   assign done     = (awvalid & awready & wready) | (arvalid & arready);
   assign cmd_full = vld_q & ~done;

   // Valid bit, load wins over a completing handshake
   always_ff @(posedge bus_clk or negedge arst_n) begin
      if (!arst_n) begin
         vld_q <= 1'b0;
      end else if (cmd_load) begin
         vld_q <= 1'b1;
      end else if (done || (cmd_flush && !wr_q)) begin
         vld_q <= 1'b0;                  // A posted write is never dropped
      end
   end

   // Entry payload
   always_ff @(posedge bus_clk) begin
      if (cmd_load) begin
         wr_q      <= write_q;
         cmd_addr  <= addr_q;
         cmd_size  <= size_q;
         cmd_wdata <= hwdata;            // Live data phase
         cmd_strb  <= strb_nxt;
      end
   end

   // ********************************************************************
   // AXI channel outputs
   // ********************************************************************
   assign awvalid = vld_q & wr_q;
   assign awaddr  = cmd_addr;
   assign awsize  = cmd_size;
   assign wvalid  = vld_q & wr_q;        // Paired with AW
   assign wdata   = cmd_wdata;
   assign wstrb   = cmd_strb;
   assign arvalid = vld_q & ~wr_q;
   assign araddr  = cmd_addr;
   assign arsize  = cmd_size;

endmodule

// File: verilog/ahb_slave_ctrl.sv
// AHB-Lite slave controller for the bridge
// Runs the bridge FSM, captures the address phase, builds
// hreadyout and the two-cycle error response, and holds
// returned read data for the AHB data phase
`timescale 1ns/1ps

module ahb_slave_ctrl
   import ahb_axi_pkg::*;
(
   input  logic    bus_clk,
   input  logic    arst_n,
   input  addr_t   haddr,
   input  hsize_t  hsize,
   input  htrans_t htrans,
   input  logic    hwrite,
   input  logic    hsel,
   input  logic    hreadyin,
   input  logic    access_err,
   input  logic    cmd_full,
   input  logic    rvalid,
   input  data_t   rdata,
   input  resp_t   rresp,
   output data_t   hrdata,
   output logic    hreadyout,
   output logic    hresp,
   output addr_t   addr_q,
   output hsize_t  size_q,
   output logic    write_q,
   output logic    cmd_load,
   output logic    cmd_flush
);

   bridge_state_t state, state_nxt;
   logic          hready;              // Bus-wide ready, this slave included
   logic          accept;              // Address phase taken this cycle
   logic          hresp_q;
   logic          hready_q;
   logic          rd_err_q;            // R beat came back with error

   assign hready = hreadyout & hreadyin;
   assign accept = hready & hsel & htrans[1];

   // ********************************************************************
   // Response generation
   // ********************************************************************
   // Error sources: illegal captured access, read error, or second error cycle
   assign hresp = (((state == WR) | (state == RD)) & access_err) |
                  rd_err_q |
                  (hresp_q & ~hready_q);

   // First error cycle holds low, second releases
   // Otherwise ready in IDLE, and in WR unless the buffer is still busy
   always_comb begin
      if (hresp) begin
         hreadyout = hresp_q & ~hready_q;
      end else begin
         hreadyout = (state == IDLE) | ((state == WR) & ~cmd_full);
      end
   end

   // Only read entries are dropped by the buffer, posted writes finish
   assign cmd_flush = hresp;

   // ********************************************************************
   // Bridge FSM
   // ********************************************************************
   always_comb begin
      state_nxt = state;
      cmd_load  = 1'b0;
      case (state)
         IDLE: begin
            if (accept) state_nxt = hwrite ? WR : RD;
         end
         WR: begin
            cmd_load = ~cmd_full & ~hresp;                   // hwdata is valid now
            if (hresp) begin
               state_nxt = IDLE;
            end else if (!cmd_full) begin
               state_nxt = accept ? (hwrite ? WR : RD) : IDLE; // Pipelined next phase
            end
         end
         RD: begin
            cmd_load = ~cmd_full & ~hresp;
            if (hresp) begin
               state_nxt = IDLE;
            end else if (!cmd_full) begin
               state_nxt = PEND;                             // AR goes out next cycle
            end
         end
         PEND: begin
            if (rvalid) state_nxt = IDLE;                    // Data shown next cycle
         end
         default: state_nxt = IDLE;
      endcase
   end

   // ********************************************************************
   // Registers
   // ********************************************************************
   always_ff @(posedge bus_clk or negedge arst_n) begin
      if (!arst_n) begin
         state    <= IDLE;
         hresp_q  <= 1'b0;
         hready_q <= 1'b0;
         rd_err_q <= 1'b0;
      end else begin
         state    <= state_nxt;
         hresp_q  <= hresp;
         hready_q <= hreadyout;
         rd_err_q <= (state == PEND) & rvalid & (|rresp); // One-cycle flag
      end
   end

   // Address phase payload
   always_ff @(posedge bus_clk) begin
      if (accept) begin
         addr_q  <= haddr;
         size_q  <= hsize;
         write_q <= hwrite;
      end
   end

   // Read return buffer
   always_ff @(posedge bus_clk) begin
      if ((state == PEND) && rvalid) hrdata <= rdata;
   end

endmodule

// File: verilog/ahb_axi_bridge.sv
// AHB-Lite slave to AXI4 master bridge, top level
// One transfer in flight. The AHB controller captures the address
// phase, the access checker judges it, and the command buffer
// issues the AXI AW/W or AR beat
`timescale 1ns/1ps

module ahb_axi_bridge
   import ahb_axi_pkg::*;
(
   input  logic    bus_clk,
   input  logic    arst_n,

   // AHB-Lite slave port
   input  addr_t   haddr,
   input  hsize_t  hsize,
   input  htrans_t htrans,
   input  logic    hwrite,
   input  data_t   hwdata,
   input  logic    hsel,
   input  logic    hreadyin,
   output data_t   hrdata,
   output logic    hreadyout,
   output logic    hresp,

   // AXI write address and data
   output logic    awvalid,
   output addr_t   awaddr,
   output hsize_t  awsize,
   input  logic    awready,
   output logic    wvalid,
   output data_t   wdata,
   output strb_t   wstrb,
   input  logic    wready,

   // AXI read address and data
   output logic    arvalid,
   output addr_t   araddr,
   output hsize_t  arsize,
   input  logic    arready,
   input  logic    rvalid,
   input  data_t   rdata,
   input  resp_t   rresp
);

   // Captured address phase
   addr_t  addr_q;
   hsize_t size_q;
   logic   write_q;

   logic   access_err;                  // Captured transfer is illegal
   logic   cmd_load;                    // Load command entry
   logic   cmd_flush;                   // Drop entry on error
   logic   cmd_full;                    // Entry busy this cycle

   ahb_slave_ctrl u_ctrl (
      .bus_clk   (bus_clk),
      .arst_n    (arst_n),
      .haddr     (haddr),
      .hsize     (hsize),
      .htrans    (htrans),
      .hwrite    (hwrite),
      .hsel      (hsel),
      .hreadyin  (hreadyin),
      .access_err(access_err),
      .cmd_full  (cmd_full),
      .rvalid    (rvalid),
      .rdata     (rdata),
      .rresp     (rresp),
      .hrdata    (hrdata),
      .hreadyout (hreadyout),
      .hresp     (hresp),
      .addr_q    (addr_q),
      .size_q    (size_q),
      .write_q   (write_q),
      .cmd_load  (cmd_load),
      .cmd_flush (cmd_flush)
   );

   ahb_access_check u_check (
      .addr_q    (addr_q),
      .size_q    (size_q),
      .write_q   (write_q),
      .access_err(access_err)
   );

   axi_cmd_buf u_cmd (
      .bus_clk  (bus_clk),
      .arst_n   (arst_n),
      .cmd_load (cmd_load),
      .cmd_flush(cmd_flush),
      .addr_q   (addr_q),
      .size_q   (size_q),
      .write_q  (write_q),
      .hwdata   (hwdata),
      .cmd_full (cmd_full),
      .awvalid  (awvalid),
      .awaddr   (awaddr),
      .awsize   (awsize),
      .awready  (awready),
      .wvalid   (wvalid),
      .wdata    (wdata),
      .wstrb    (wstrb),
      .wready   (wready),
      .arvalid  (arvalid),
      .araddr   (araddr),
      .arsize   (arsize),
      .arready  (arready)
   );

endmodule

// File: verification/tb_tasks.svh
// AHB driver, compare and directed test tasks for the bridge testbench
// Included inside the testbench top, uses its signals and logs
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// *************************************************************************
// Compare tasks
// *************************************************************************
task automatic check_addr(input addr_t got, input addr_t exp, input string what);
   checks++;
   if (got !== exp) begin
      $display("Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
   end
endtask

task automatic check_data(input data_t got, input data_t exp, input string what);
   checks++;
   if (got !== exp) begin
      $display("Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
   end
endtask

task automatic check_strb(input strb_t got, input strb_t exp, input string what);
   checks++;
   if (got !== exp) begin
      $display("Error at time %0t: %s is %b, expected %b", $time, what, got, exp);
      errors++;
   end
endtask

task automatic check_size(input hsize_t got, input hsize_t exp, input string what);
   checks++;
   if (got !== exp) begin
      $display("Error at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
      errors++;
   end
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
   checks++;
   if (got !== exp) begin
      $display("Error at time %0t: %s is %b, expected %b", $time, what, got, exp);
      errors++;
   end
endtask

// Byte lanes covered by a transfer, counted up from the addressed byte
function automatic strb_t lane_mask(input addr_t a, input hsize_t s);
   strb_t m;
   int    first;
   int    bytes;
   int    i;
   first = int'(a[2:0]);
   bytes = 1 << s;
   for (i = 0; i < 8; i++) begin
      m[i] = (i >= first) && (i < first + bytes);
   end
   return m;
endfunction

task automatic finish_test(input string name, input int err0);
   tests_run++;
   if (errors == err0) $display("Test %s: ok", name);
   else $display("Test %s: %0d mismatches", name, errors - err0);
endtask

// *************************************************************************
// AHB driver
// *************************************************************************
// Waits for hreadyout and records the hresp pattern on the way
task automatic wait_ready();
   int n;
   n          = 0;
   resp_count = 0;
   resp_prev  = 1'b0;
   while (!hreadyout && n < WAIT_LIMIT) begin
      if (hresp) resp_count++;
      resp_prev = hresp;
      @(negedge bus_clk);
      #1;                                // Outputs settled after the drive
      n++;
   end
   if (hresp) resp_count++;
   resp_last   = hresp;
   data_cycles = n + 1;
   if (!hreadyout) begin
      $display("Timeout at time %0t: hreadyout stayed low for %0d cycles", $time, n);
      errors++;
   end
endtask

// One non-pipelined transfer, address phase then data phase
task automatic ahb_xfer(input addr_t a, input hsize_t s, input logic w, input data_t d);
   @(negedge bus_clk);
   haddr  = a;
   hsize  = s;
   hwrite = w;
   hsel   = 1'b1;
   htrans = HTRANS_NONSEQ;
   #1;
   wait_ready();
   @(negedge bus_clk);
   hsel   = 1'b0;
   htrans = HTRANS_IDLE;
   if (w) hwdata = d;                    // Write data in the data phase
   #1;
   wait_ready();
endtask

task automatic wait_writes(input int n);
   int k;
   k = 0;
   while (wr_addr_log.size() < n && k < WAIT_LIMIT) begin
      @(negedge bus_clk);
      #1;
      k++;
   end
   if (wr_addr_log.size() < n) begin
      $display("Timeout at time %0t: AXI write %0d never reached the slave", $time, n);
      errors++;
   end
endtask

// Logged AXI write against the AHB transfer that caused it
task automatic check_write(input int idx, input addr_t a, input hsize_t s,
                           input data_t d, input string tag);
   if (idx >= wr_addr_log.size()) return;
   check_addr(wr_addr_log[idx], a, {tag, " awaddr"});
   check_size(wr_size_log[idx], s, {tag, " awsize"});
   check_data(wr_data_log[idx], d, {tag, " wdata"});
   check_strb(wr_strb_log[idx], lane_mask(a, s), {tag, " wstrb"});
endtask

// Two-cycle error and nothing on AXI
task automatic expect_error(input addr_t a, input hsize_t s, input logic w,
                            input string tag);
   int v0;
   v0 = valid_count;
   ahb_xfer(a, s, w, 64'hdead_beef_0bad_f00d);
   check_bit(resp_count == 2, 1'b1, {tag, " two hresp cycles"});
   check_bit(resp_prev, 1'b1, {tag, " hresp with hreadyout low"});
   check_bit(resp_last, 1'b1, {tag, " hresp with hreadyout high"});
   repeat (3) @(negedge bus_clk);
   #1;
   check_bit(valid_count != v0, 1'b0, {tag, " AXI valid raised"});
endtask

// *************************************************************************
// Directed tests
// *************************************************************************
task automatic test_reset_state();
   int err0;
   err0 = errors;
   check_bit(hreadyout, 1'b1, "hreadyout after reset");
   check_bit(hresp, 1'b0, "hresp after reset");
   check_bit(awvalid | wvalid, 1'b0, "write valids after reset");
   check_bit(arvalid, 1'b0, "arvalid after reset");
   finish_test("reset state", err0);
endtask

task automatic test_word_write();
   int    err0;
   int    mark;
   addr_t a;
   data_t d;
   err0     = errors;
   mark     = wr_addr_log.size();
   a        = DCCM_BASE + 32'h0000_0124;  // Upper word of a doubleword
   d        = 64'h1122_3344_5566_7788;
   wr_delay = 1;
   ahb_xfer(a, SIZE_WORD, 1'b1, d);
   check_bit(resp_count == 0, 1'b1, "word write hresp low");
   check_bit(data_cycles == 1, 1'b1, "word write data phase without wait");
   wait_writes(mark + 1);
   check_write(mark, a, SIZE_WORD, d, "word write");
   wr_delay = 0;
   finish_test("word write", err0);
endtask

task automatic test_dword_read();
   int    err0;
   int    mark;
   addr_t a;
   err0      = errors;
   mark      = rd_addr_log.size();
   a         = DCCM_BASE + 32'h0000_0a08;
   rd_value  = 64'hcafe_f00d_0123_4567;
   rd_status = 2'b00;
   rd_delay  = 2;
   ahb_xfer(a, SIZE_DWORD, 1'b0, '0);
   check_bit(resp_count == 0, 1'b1, "dword read hresp low");
   check_data(hrdata, 64'hcafe_f00d_0123_4567, "dword read hrdata");
   check_addr(rd_addr_log[mark], a, "dword read araddr");
   check_size(rd_size_log[mark], SIZE_DWORD, "dword read arsize");
   rd_delay = 0;
   finish_test("dword read", err0);
endtask

task automatic test_illegal();
   int err0;
   err0 = errors;
   expect_error(32'h1000_0000, SIZE_WORD, 1'b0, "unmapped read");
   expect_error(DCCM_BASE + 32'h11, SIZE_HALF, 1'b0, "misaligned halfword");
   expect_error(DCCM_BASE + 32'h23, SIZE_BYTE, 1'b1, "DCCM byte write");
   expect_error(ICCM_BASE + 32'h08, SIZE_WORD, 1'b1, "ICCM word write");
   finish_test("illegal accesses", err0);
endtask

task automatic test_read_error();
   int err0;
   int mark;
   err0      = errors;
   mark      = rd_addr_log.size();
   rd_status = 2'b10;                    // SLVERR
   rd_delay  = 1;
   ahb_xfer(DCCM_BASE + 32'h0000_0300, SIZE_WORD, 1'b0, '0);
   check_bit(rd_addr_log.size() == mark + 1, 1'b1, "read error AR issued");
   check_bit(resp_count == 2, 1'b1, "read error two hresp cycles");
   check_bit(resp_prev, 1'b1, "read error hresp with hreadyout low");
   check_bit(resp_last, 1'b1, "read error hresp with hreadyout high");
   rd_status = 2'b00;
   rd_delay  = 0;
   finish_test("read error", err0);
endtask

// Second write's data phase stalls until the first leaves the buffer
task automatic test_back_pressure();
   int    err0;
   int    mark;
   addr_t a0;
   addr_t a1;
   err0     = errors;
   mark     = wr_addr_log.size();
   a0       = DCCM_BASE + 32'h0000_0040;
   a1       = DCCM_BASE + 32'h0000_0048;
   wr_delay = 4;
   @(negedge bus_clk);
   haddr  = a0;
   hsize  = SIZE_WORD;
   hwrite = 1'b1;
   hsel   = 1'b1;
   htrans = HTRANS_NONSEQ;
   #1;
   wait_ready();
   @(negedge bus_clk);
   hwdata = 64'h0000_0000_a5a5_0001;     // First data phase, second address
   haddr  = a1;
   hsize  = SIZE_DWORD;
   #1;
   check_bit(hreadyout, 1'b1, "back-pressure first data phase ready");
   @(negedge bus_clk);
   hsel   = 1'b0;
   htrans = HTRANS_IDLE;
   hwdata = 64'h5a5a_0002_5a5a_0003;
   #1;
   check_bit(hreadyout, 1'b0, "back-pressure hreadyout while full");
   check_bit(awvalid, 1'b1, "back-pressure first write pending");
   wait_ready();
   check_bit(resp_count == 0, 1'b1, "back-pressure hresp low");
   wait_writes(mark + 2);
   check_write(mark, a0, SIZE_WORD, 64'h0000_0000_a5a5_0001, "back-pressure first");
   check_write(mark + 1, a1, SIZE_DWORD, 64'h5a5a_0002_5a5a_0003, "back-pressure second");
   wr_delay = 0;
   finish_test("back-pressure", err0);
endtask

task automatic test_random_access();
   int          err0;
   int          n;
   int          mark;
   logic [31:0] r;
   logic [31:0] off;
   logic        w;
   addr_t       a;
   hsize_t      s;
   data_t       d;
   err0 = errors;
   for (n = 0; n < 16; n++) begin
      r         = $random(seed);
      off       = $random(seed);
      d[63:32]  = $random(seed);
      d[31:0]   = $random(seed);
      w         = r[0];
      s         = w ? {2'b01, r[1]} : {1'b0, r[2:1]};  // Writes are word or dword
      a         = DCCM_BASE | (off & 32'h0000_ffff & ~((32'd1 << s) - 32'd1));
      wr_delay  = int'(r[4:3]);
      rd_delay  = int'(r[6:5]);
      if (w) begin
         mark = wr_addr_log.size();
         ahb_xfer(a, s, 1'b1, d);
         check_bit(resp_count == 0, 1'b1, "random write hresp low");
         wait_writes(mark + 1);
         check_write(mark, a, s, d, "random write");
      end else begin
         mark      = rd_addr_log.size();
         rd_value  = d;
         rd_status = 2'b00;
         ahb_xfer(a, s, 1'b0, '0);
         check_bit(resp_count == 0, 1'b1, "random read hresp low");
         check_data(hrdata, d, "random read hrdata");
         check_addr(rd_addr_log[mark], a, "random read araddr");
         check_size(rd_size_log[mark], s, "random read arsize");
      end
   end
   wr_delay = 0;
   rd_delay = 0;
   finish_test("random access", err0);
endtask

`endif

// File: verification/tb_ahb_axi_bridge.sv
// Testbench for the AHB-Lite to AXI4 bridge
// Drives AHB transfers into the DUT, answers its AXI requests with
// a single-beat slave model and checks both sides of each transfer
`timescale 1ns/1ps

module tb_ahb_axi_bridge
   import ahb_axi_pkg::*;
();

   localparam int CLK_PERIOD = 20;
   localparam int NUM_TESTS  = 7;
   localparam int WAIT_LIMIT = 100;     // Cycles allowed for one handshake

   logic    bus_clk;
   logic    arst_n;

   // AHB side
   addr_t   haddr;
   hsize_t  hsize;
   htrans_t htrans;
   logic    hwrite;
   data_t   hwdata;
   logic    hsel;
   logic    hreadyin;
   data_t   hrdata;
   logic    hreadyout;
   logic    hresp;

   // AXI side
   logic    awvalid;
   addr_t   awaddr;
   hsize_t  awsize;
   logic    awready;
   logic    wvalid;
   data_t   wdata;
   strb_t   wstrb;
   logic    wready;
   logic    arvalid;
   addr_t   araddr;
   hsize_t  arsize;
   logic    arready;
   logic    rvalid;
   data_t   rdata;
   resp_t   rresp;

   // Slave model controls, set by the tests
   int      wr_delay = 0;               // Cycles before AW+W accepted
   int      rd_delay = 0;               // Cycles before AR accepted and before R
   data_t   rd_value = '0;
   resp_t   rd_status = 2'b00;

   // Slave model logs, one entry per accepted request
   addr_t   wr_addr_log[$];
   hsize_t  wr_size_log[$];
   data_t   wr_data_log[$];
   strb_t   wr_strb_log[$];
   addr_t   rd_addr_log[$];
   hsize_t  rd_size_log[$];
   int      valid_count = 0;            // Cycles with any AXI valid high

   // Bookkeeping
   int      errors = 0;
   int      checks = 0;
   int      tests_run = 0;
   int      seed;

   // Shape of the last AHB data phase
   int      resp_count;                 // Cycles with hresp high
   int      data_cycles;
   logic    resp_prev;                  // hresp one cycle before completion
   logic    resp_last;                  // hresp in the completing cycle

   ahb_axi_bridge u_dut (
      .bus_clk  (bus_clk),
      .arst_n   (arst_n),
      .haddr    (haddr),
      .hsize    (hsize),
      .htrans   (htrans),
      .hwrite   (hwrite),
      .hwdata   (hwdata),
      .hsel     (hsel),
      .hreadyin (hreadyin),
      .hrdata   (hrdata),
      .hreadyout(hreadyout),
      .hresp    (hresp),
      .awvalid  (awvalid),
      .awaddr   (awaddr),
      .awsize   (awsize),
      .awready  (awready),
      .wvalid   (wvalid),
      .wdata    (wdata),
      .wstrb    (wstrb),
      .wready   (wready),
      .arvalid  (arvalid),
      .araddr   (araddr),
      .arsize   (arsize),
      .arready  (arready),
      .rvalid   (rvalid),
      .rdata    (rdata),
      .rresp    (rresp)
   );

   initial begin
      bus_clk = 1'b0;
      forever #(CLK_PERIOD / 2) bus_clk = ~bus_clk;
   end

   // *********************************************************************
   // AXI slave model
   // *********************************************************************
   // AW and W taken together after wr_delay cycles, logged when accepted
   initial begin
      int wait_cnt;
      wait_cnt = 0;
      awready  = 1'b0;
      wready   = 1'b0;
      forever begin
         @(negedge bus_clk);
         if (awready) begin
            awready  = 1'b0;             // Handshake done at last edge
            wready   = 1'b0;
            wait_cnt = 0;
         end else if (awvalid && wvalid) begin
            if (wait_cnt >= wr_delay) begin
               awready = 1'b1;
               wready  = 1'b1;
               wr_addr_log.push_back(awaddr);
               wr_size_log.push_back(awsize);
               wr_data_log.push_back(wdata);
               wr_strb_log.push_back(wstrb);
            end else begin
               wait_cnt++;
            end
         end
      end
   end

   // AR taken after rd_delay cycles, one R beat rd_delay cycles later
   initial begin
      int   ar_wait;
      int   r_wait;
      logic r_due;
      ar_wait = 0;
      r_wait  = 0;
      r_due   = 1'b0;
      arready = 1'b0;
      rvalid  = 1'b0;
      rdata   = '0;
      rresp   = 2'b00;
      forever begin
         @(negedge bus_clk);
         if (arready) begin
            arready = 1'b0;
            ar_wait = 0;
            r_wait  = 0;
            r_due   = 1'b1;
         end else if (arvalid) begin
            if (ar_wait >= rd_delay) begin
               arready = 1'b1;
               rd_addr_log.push_back(araddr);
               rd_size_log.push_back(arsize);
            end else begin
               ar_wait++;
            end
         end
         if (rvalid) begin
            rvalid = 1'b0;               // Single beat
         end else if (r_due) begin
            if (r_wait >= rd_delay) begin
               rvalid = 1'b1;
               rdata  = rd_value;
               rresp  = rd_status;
               r_due  = 1'b0;
            end else begin
               r_wait++;
            end
         end
      end
   end

   // Any request on the AXI side, used by the error tests
   always @(negedge bus_clk) begin
      if (awvalid || wvalid || arvalid) valid_count++;
   end

   // Watchdog, sized for 200 cycles per test plus reset
   initial begin
      #(CLK_PERIOD * (NUM_TESTS * 200 + 10));
      $display("Watchdog expired after %0d cycles, the DUT or a handshake hung",
               NUM_TESTS * 200 + 10);
      $display("*** TEST FAILED ***");
      $finish;
   end

   `include "tb_tasks.svh"

   // *********************************************************************
   // Test sequence
   // *********************************************************************
   initial begin
      arst_n   = 1'b0;
      haddr    = '0;
      hsize    = SIZE_BYTE;
      htrans   = HTRANS_IDLE;
      hwrite   = 1'b0;
      hwdata   = '0;
      hsel     = 1'b0;
      hreadyin = 1'b1;                   // Only slave on the bus
      seed     = 32'h340c_6b9b;
      repeat (2) @(posedge bus_clk);
      @(negedge bus_clk);
      arst_n = 1'b1;
      #1;
      test_reset_state();
      test_word_write();
      test_dword_read();
      test_illegal();
      test_read_error();
      test_back_pressure();
      test_random_access();
      $display("Tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
      if (errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

// File: ahb_axi_bridge.f
+incdir+verification
verilog/ahb_axi_pkg.sv
verilog/ahb_access_check.sv
verilog/axi_cmd_buf.sv
verilog/ahb_slave_ctrl.sv
verilog/ahb_axi_bridge.sv
verification/tb_ahb_axi_bridge.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the AHB to AXI bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
   --top-module tb_ahb_axi_bridge \
   -f ahb_axi_bridge.f \
   -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -qF '*** TEST FAILED ***' sim.log; then
   echo "Simulation reported failure"
   exit 1
fi
echo "Simulation finished without failure"
